//--- cl_ddr_glue_top.sv
//----------------------------------------------------------
// DDR channel glue top: reset slices, control and status,
// per-channel counters and scrub tracking, status slave
//----------------------------------------------------------
`default_nettype none

module cl_ddr_glue_top #(
   parameter int                     RST_STAGES            = 4,
   parameter cl_glue_pkg::ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                     SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                                            clk,
   input  logic                                            sync_rst_n,
   input  cl_glue_pkg::reg_t                               ctl0,
   input  logic                                            flr_assert,
   input  cl_glue_pkg::ddr_hs_t [cl_glue_pkg::NUM_DDR-1:0] ddr_mon,
   input  cl_glue_pkg::axil_req_t                          axil_req,
   output logic                                            flr_done,
   output cl_glue_pkg::reg_t                               id0,
   output cl_glue_pkg::reg_t                               id1,
   output cl_glue_pkg::axil_rsp_t                          axil_rsp
);

   logic                                              ctl_rst_n;
   logic                                              chan_rst_n;
   logic                                              regs_rst_n;
   logic [cl_glue_pkg::NUM_DDR-1:0]                   scrub_en;
   logic [cl_glue_pkg::NUM_DDR-1:0]                   scrub_done;
   cl_glue_pkg::ddr_addr_t [cl_glue_pkg::NUM_DDR-1:0] scrub_addr;
   cl_glue_pkg::chan_cnt_t [cl_glue_pkg::NUM_DDR-1:0] counts;

   rst_slice_tree #(.RST_STAGES(RST_STAGES)) i_rst_slice_tree (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl_rst_n  (ctl_rst_n),
      .chan_rst_n (chan_rst_n),
      .regs_rst_n (regs_rst_n)
   );

   ctl_status i_ctl_status (
      .clk        (clk),
      .rst_n      (ctl_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .scrub_addr (scrub_addr),
      .scrub_en   (scrub_en),
      .flr_done   (flr_done),
      .id0        (id0),
      .id1        (id1)
   );

   // One scrub tracker and one counter block per DDR channel
   for (genvar ch = 0; ch < cl_glue_pkg::NUM_DDR; ch++)
   begin : g_chan
      scrub_progress #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      ) i_scrub_progress (
         .clk    (clk),
         .rst_n  (chan_rst_n),
         .enable (scrub_en[ch]),
         .mon    (ddr_mon[ch]),
         .addr   (scrub_addr[ch]),
         .done   (scrub_done[ch])
      );

      ddr_traffic_counter i_ddr_traffic_counter (
         .clk    (clk),
         .rst_n  (chan_rst_n),
         .mon    (ddr_mon[ch]),
         .counts (counts[ch])
      );
   end

   stat_regs_axil i_stat_regs_axil (
      .clk        (clk),
      .rst_n      (regs_rst_n),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .counts     (counts),
      .scrub_done (scrub_done)
   );

endmodule

`default_nettype wire

//--- cl_glue_pkg.sv
//----------------------------------------------------------
// Shared widths, bus structs, register map and ID constants
// for the DDR channel glue. Referenced by scoped names.
//----------------------------------------------------------
`default_nettype none

package cl_glue_pkg;

   // Channel index 0 is A, 1 is B, 2 is C, 3 is D
   localparam int NUM_DDR = 4;

   typedef logic [63:0] ddr_addr_t;
   typedef logic [31:0] reg_t;
   typedef logic [31:0] cnt_t;

   // Handshake pairs of one monitored DDR AXI bus
   typedef struct packed {
      logic awvalid;
      logic awready;
      logic wvalid;
      logic wready;
      logic arvalid;
      logic arready;
      logic rvalid;
      logic rready;
      logic bvalid;
      logic bready;
   } ddr_hs_t;

   typedef struct packed {
      cnt_t aw;
      cnt_t w;
      cnt_t ar;
      cnt_t r;
      cnt_t b;
   } chan_cnt_t;

   // AXI4-Lite signals driven by the master
   typedef struct packed {
      logic       awvalid;
      logic [31:0] awaddr;
      logic       wvalid;
      logic [31:0] wdata;
      logic [3:0] wstrb;
      logic       bready;
      logic       arvalid;
      logic [31:0] araddr;
      logic       rready;
   } axil_req_t;

   // AXI4-Lite signals driven by the slave
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
      logic       arready;
      logic       rvalid;
      logic [31:0] rdata;
      logic [1:0] rresp;
   } axil_rsp_t;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   localparam reg_t CL_ID0 = 32'hF000_1D0F;
   localparam reg_t CL_ID1 = 32'h1D51_FEDC;

   // Register map
   localparam reg_t CNT_CH_STRIDE = 32'h20;
   localparam reg_t STATUS_ADDR   = 32'h80;

   localparam int BEAT_BYTES = 64;

endpackage

`default_nettype wire

//--- ctl_status.sv
//----------------------------------------------------------
// Control word capture, scrub enables, debug ID mux and the
// FLR acknowledge toward the shell
//----------------------------------------------------------
`default_nettype none

module ctl_status
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  cl_glue_pkg::reg_t                                 ctl0,
   input  logic                                              flr_assert,
   input  cl_glue_pkg::ddr_addr_t [cl_glue_pkg::NUM_DDR-1:0] scrub_addr,
   output logic [cl_glue_pkg::NUM_DDR-1:0]                   scrub_en,
   output logic                                              flr_done,
   output cl_glue_pkg::reg_t                                 id0,
   output cl_glue_pkg::reg_t                                 id1
);

   cl_glue_pkg::reg_t      ctl0_q;
   logic                   flr_assert_q;
   logic                   dbg_en;
   logic [2:0]             dbg_sel;
   cl_glue_pkg::ddr_addr_t dbg_addr;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ctl0_q       <= '0;
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         ctl0_q       <= ctl0;
         flr_assert_q <= flr_assert;
         // Toggles for as long as the FLR request stays up
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // Bits 3:0 enable A, B, D, C in that order
   assign scrub_en[0] = ctl0_q[0];
   assign scrub_en[1] = ctl0_q[1];
   assign scrub_en[3] = ctl0_q[2];
   assign scrub_en[2] = ctl0_q[3];

   // Bit 31 debug enable, bits 30:28 channel select
   assign dbg_en  = ctl0_q[31];
   assign dbg_sel = ctl0_q[30:28];

   always_comb
   begin
      case (dbg_sel)
         3'd3:    dbg_addr = scrub_addr[2];
         3'd2:    dbg_addr = scrub_addr[3];
         3'd1:    dbg_addr = scrub_addr[1];
         default: dbg_addr = scrub_addr[0];
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         id0 <= dbg_addr[31:0];
         id1 <= dbg_addr[63:32];
      end
      else
      begin
         id0 <= cl_glue_pkg::CL_ID0;
         id1 <= cl_glue_pkg::CL_ID1;
      end
   end

endmodule

`default_nettype wire

//--- ddr_traffic_counter.sv
//----------------------------------------------------------
// Handshake counters for the five channels of one DDR bus.
// Each counter wraps at 2^32.
//----------------------------------------------------------
`default_nettype none

module ddr_traffic_counter
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  cl_glue_pkg::ddr_hs_t   mon,
   output cl_glue_pkg::chan_cnt_t counts
);

   logic aw_fire;
   logic w_fire;
   logic ar_fire;
   logic r_fire;
   logic b_fire;

   assign aw_fire = mon.awvalid && mon.awready;
   assign w_fire  = mon.wvalid  && mon.wready;
   assign ar_fire = mon.arvalid && mon.arready;
   assign r_fire  = mon.rvalid  && mon.rready;
   assign b_fire  = mon.bvalid  && mon.bready;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         counts <= '0;
      end
      else
      begin
         if (aw_fire)
            counts.aw <= counts.aw + 32'd1;
         if (w_fire)
            counts.w  <= counts.w + 32'd1;
         if (ar_fire)
            counts.ar <= counts.ar + 32'd1;
         if (r_fire)
            counts.r  <= counts.r + 32'd1;
         if (b_fire)
            counts.b  <= counts.b + 32'd1;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
cl_glue_pkg.sv
rst_slice_tree.sv
ctl_status.sv
scrub_progress.sv
ddr_traffic_counter.sv
stat_regs_axil.sv
cl_ddr_glue_top.sv
tb_cl_ddr_glue.sv

//--- rst_slice_tree.sv
//----------------------------------------------------------
// Per-block reset slices. Each copy asserts with the top
// reset and releases RST_STAGES clocks later.
//----------------------------------------------------------
`default_nettype none

module rst_slice_tree #(
   parameter int RST_STAGES = 4
)
(
   input  logic clk,
   input  logic sync_rst_n,
   output logic ctl_rst_n,
   output logic chan_rst_n,
   output logic regs_rst_n
);

   // Chain 0 feeds control, chain 1 the channels and chain 2 the registers
   logic [2:0][RST_STAGES-1:0] slice_pipe;

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         slice_pipe <= '0;
      end
      else
      begin
         for (int c = 0; c < 3; c++)
         begin
            slice_pipe[c][0] <= 1'b1;
            for (int s = 1; s < RST_STAGES; s++)
            begin
               slice_pipe[c][s] <= slice_pipe[c][s-1];
            end
         end
      end
   end

   assign ctl_rst_n  = slice_pipe[0][RST_STAGES-1];
   assign chan_rst_n = slice_pipe[1][RST_STAGES-1];
   assign regs_rst_n = slice_pipe[2][RST_STAGES-1];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the DDR glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_cl_ddr_glue -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with an error"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^STATUS: PASS$'; then
   exit 0
fi
exit 1

//--- scrub_progress.sv
//----------------------------------------------------------
// Scrub progress of one DDR channel, advanced by accepted
// write bursts on that channel's bus
//----------------------------------------------------------
`default_nettype none

module scrub_progress #(
   parameter cl_glue_pkg::ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                     SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  cl_glue_pkg::ddr_hs_t   mon,
   output cl_glue_pkg::ddr_addr_t addr,
   output logic                   done
);

   // Bytes covered by one scrub burst
   localparam cl_glue_pkg::ddr_addr_t BURST_BYTES =
      cl_glue_pkg::ddr_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * cl_glue_pkg::BEAT_BYTES);

   logic                   aw_fire;
   cl_glue_pkg::ddr_addr_t next_addr;

   assign aw_fire   = mon.awvalid && mon.awready;
   assign next_addr = addr + BURST_BYTES;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         addr <= '0;
         done <= 1'b0;
      end
      else if (!enable)
      begin
         addr <= '0;
         done <= 1'b0;
      end
      else if (aw_fire && !done)
      begin
         addr <= next_addr;
         done <= (next_addr > SCRB_MAX_ADDR);
      end
   end

endmodule

`default_nettype wire

//--- stat_regs_axil.sv
//----------------------------------------------------------
// AXI4-Lite status slave. Reads return the traffic counters
// and scrub done bits; every write gets SLVERR.
//----------------------------------------------------------
`default_nettype none

module stat_regs_axil
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  cl_glue_pkg::axil_req_t                            axil_req,
   output cl_glue_pkg::axil_rsp_t                            axil_rsp,
   input  cl_glue_pkg::chan_cnt_t [cl_glue_pkg::NUM_DDR-1:0] counts,
   input  logic [cl_glue_pkg::NUM_DDR-1:0]                   scrub_done
);

   localparam int CH_W = $clog2(cl_glue_pkg::NUM_DDR);
   localparam cl_glue_pkg::reg_t CNT_SPAN =
      cl_glue_pkg::reg_t'(cl_glue_pkg::NUM_DDR) * cl_glue_pkg::CNT_CH_STRIDE;

   logic                   acc_en;
   logic                   rvalid;
   logic                   bvalid;
   cl_glue_pkg::reg_t      rdata;
   logic [1:0]             rresp;
   logic                   ar_fire;
   logic                   wr_fire;
   cl_glue_pkg::reg_t      ch_word;
   cl_glue_pkg::reg_t      kind_off;
   logic [CH_W-1:0]        rd_chan;
   cl_glue_pkg::chan_cnt_t rd_cnt;
   cl_glue_pkg::reg_t      rd_data_nxt;
   logic [1:0]             rd_resp_nxt;

   // ---------------------------------------------------------
   // Handshakes
   // ---------------------------------------------------------
   assign ar_fire = acc_en && !rvalid && axil_req.arvalid;
   assign wr_fire = acc_en && !bvalid && axil_req.awvalid && axil_req.wvalid;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         acc_en <= 1'b0;
         rvalid <= 1'b0;
         bvalid <= 1'b0;
      end
      else
      begin
         acc_en <= 1'b1;
         if (ar_fire)
            rvalid <= 1'b1;
         else if (axil_req.rready)
            rvalid <= 1'b0;
         if (wr_fire)
            bvalid <= 1'b1;
         else if (axil_req.bready)
            bvalid <= 1'b0;
      end
   end

   // ---------------------------------------------------------
   // Read decode
   // ---------------------------------------------------------
   assign ch_word  = axil_req.araddr / cl_glue_pkg::CNT_CH_STRIDE;
   assign kind_off = axil_req.araddr % cl_glue_pkg::CNT_CH_STRIDE;
   assign rd_chan  = ch_word[CH_W-1:0];
   assign rd_cnt   = counts[rd_chan];

   always_comb
   begin
      rd_data_nxt = '0;
      rd_resp_nxt = cl_glue_pkg::RESP_SLVERR;
      if (axil_req.araddr[31:2] == cl_glue_pkg::STATUS_ADDR[31:2])
      begin
         rd_data_nxt = cl_glue_pkg::reg_t'(scrub_done);
         rd_resp_nxt = cl_glue_pkg::RESP_OKAY;
      end
      else if (axil_req.araddr < CNT_SPAN)
      begin
         rd_resp_nxt = cl_glue_pkg::RESP_OKAY;
         case (kind_off[4:2])
            3'd0:    rd_data_nxt = rd_cnt.aw;
            3'd1:    rd_data_nxt = rd_cnt.w;
            3'd2:    rd_data_nxt = rd_cnt.ar;
            3'd3:    rd_data_nxt = rd_cnt.r;
            3'd4:    rd_data_nxt = rd_cnt.b;
            default: rd_resp_nxt = cl_glue_pkg::RESP_SLVERR;
         endcase
      end
   end

   // Response payload held stable while rvalid waits on rready
   always_ff @(posedge clk)
   begin
      if (ar_fire)
      begin
         rdata <= rd_data_nxt;
         rresp <= rd_resp_nxt;
      end
   end

   always_comb
   begin
      axil_rsp.awready = wr_fire;
      axil_rsp.wready  = wr_fire;
      axil_rsp.bvalid  = bvalid;
      axil_rsp.bresp   = cl_glue_pkg::RESP_SLVERR;
      axil_rsp.arready = acc_en && !rvalid;
      axil_rsp.rvalid  = rvalid;
      axil_rsp.rdata   = rdata;
      axil_rsp.rresp   = rresp;
   end

endmodule

`default_nettype wire

//--- tb_cl_ddr_glue.sv
//----------------------------------------------------------
// Random-stimulus testbench for the DDR channel glue top.
// Checks counters, scrub status, ID mux and FLR against a model.
//----------------------------------------------------------
`default_nettype none

module tb_cl_ddr_glue;

   localparam int RST_STAGES = 4;
   localparam int TIMEOUT    = 50;
   // Scrub step and limit for the default top-level parameters
   localparam logic [63:0] SCRUB_STEP  = 64'(16 * cl_glue_pkg::BEAT_BYTES);
   localparam logic [63:0] SCRUB_LIMIT = 64'h1FFF;

   typedef cl_glue_pkg::ddr_hs_t [cl_glue_pkg::NUM_DDR-1:0] mon_vec_t;

   logic                   clk;
   logic                   sync_rst_n;
   cl_glue_pkg::reg_t      ctl0;
   logic                   flr_assert;
   mon_vec_t               ddr_mon;
   cl_glue_pkg::axil_req_t axil_req;
   logic                   flr_done;
   cl_glue_pkg::reg_t      id0;
   cl_glue_pkg::reg_t      id1;
   cl_glue_pkg::axil_rsp_t axil_rsp;

   // Reference model state
   logic [31:0] rng_state;
   logic [31:0] cnt_model [4][5];
   logic [63:0] addr_model [4];
   logic [3:0]  en_model;
   logic [3:0]  done_model;

   cl_ddr_glue_top i_dut (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .ddr_mon    (ddr_mon),
      .axil_req   (axil_req),
      .flr_done   (flr_done),
      .id0        (id0),
      .id1        (id1),
      .axil_rsp   (axil_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("** Error: time %0t, %s = 0x%0h, expected 0x%0h",
                             $time, name, got, exp));
   endtask

   // Selector 3 picks C, 2 picks D, 1 picks B and any other value A
   function automatic int sel_to_chan(input logic [2:0] sel);
      case (sel)
         3'd3:    return 2;
         3'd2:    return 3;
         3'd1:    return 1;
         default: return 0;
      endcase
   endfunction

   function automatic logic [31:0] counter_addr(input int ch, input int kind);
      return 32'(ch) * cl_glue_pkg::CNT_CH_STRIDE + 32'(kind * 4);
   endfunction

   function automatic mon_vec_t random_mon();
      mon_vec_t    v;
      logic [31:0] r;
      for (int ch = 0; ch < cl_glue_pkg::NUM_DDR; ch++)
      begin
         r     = next_rand();
         v[ch] = r[25:16];
      end
      return v;
   endfunction

   // Drives one clock of monitored traffic from a falling edge
   task automatic apply_mon(input mon_vec_t v);
      logic [4:0] fire;
      ddr_mon = v;
      for (int ch = 0; ch < 4; ch++)
      begin
         fire = {v[ch].bvalid && v[ch].bready, v[ch].rvalid && v[ch].rready,
                 v[ch].arvalid && v[ch].arready, v[ch].wvalid && v[ch].wready,
                 v[ch].awvalid && v[ch].awready};
         for (int k = 0; k < 5; k++)
         begin
            if (fire[k])
               cnt_model[ch][k] = cnt_model[ch][k] + 32'd1;
         end
         if (en_model[ch] && fire[0] && !done_model[ch])
         begin
            addr_model[ch] = addr_model[ch] + SCRUB_STEP;
            if (addr_model[ch] > SCRUB_LIMIT)
               done_model[ch] = 1'b1;
         end
      end
      @(negedge clk);
   endtask

   // Drive the control word and let it reach the channels
   task automatic set_ctl(input cl_glue_pkg::reg_t value);
      ctl0 = value;
      apply_mon('0);
      apply_mon('0);
      // Index 3 is D on bit 2, index 2 is C on bit 3
      en_model = {value[2], value[3], value[1], value[0]};
      for (int ch = 0; ch < 4; ch++)
      begin
         if (!en_model[ch])
         begin
            addr_model[ch] = '0;
            done_model[ch] = 1'b0;
         end
      end
   endtask

   task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int          cycles;
      int          hold;
      logic [31:0] r;
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = 1'b0;
      cycles = 0;
      #1;
      while (!axil_rsp.arready)
      begin
         if (cycles == TIMEOUT)
            abort_run("Read address handshake timed out");
         else
         begin
            cycles++;
            @(negedge clk);
            #1;
         end
      end
      @(negedge clk);
      axil_req.arvalid = 1'b0;
      cycles = 0;
      while (!axil_rsp.rvalid)
      begin
         if (cycles == TIMEOUT)
            abort_run("Read response never arrived");
         else
         begin
            cycles++;
            @(negedge clk);
         end
      end
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      // Random back-pressure while the response must stay put
      r    = next_rand();
      hold = int'(r[17:16]);
      repeat (hold)
      begin
         @(negedge clk);
         check_value("rvalid", 64'(axil_rsp.rvalid), 64'd1);
         check_value("rdata", 64'(axil_rsp.rdata), 64'(data));
      end
      axil_req.rready = 1'b1;
      @(negedge clk);
      axil_req.rready = 1'b0;
      check_value("rvalid", 64'(axil_rsp.rvalid), 64'd0);
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int          cycles;
      int          hold;
      logic [31:0] r;
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = 4'hF;
      axil_req.bready  = 1'b0;
      cycles = 0;
      #1;
      while (!axil_rsp.awready)
      begin
         if (cycles == TIMEOUT)
            abort_run("Write address handshake timed out");
         else
         begin
            cycles++;
            @(negedge clk);
            #1;
         end
      end
      check_value("wready", 64'(axil_rsp.wready), 64'd1);
      @(negedge clk);
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      cycles = 0;
      while (!axil_rsp.bvalid)
      begin
         if (cycles == TIMEOUT)
            abort_run("Write response never arrived");
         else
         begin
            cycles++;
            @(negedge clk);
         end
      end
      resp = axil_rsp.bresp;
      r    = next_rand();
      hold = int'(r[17:16]);
      repeat (hold)
      begin
         @(negedge clk);
         check_value("bvalid", 64'(axil_rsp.bvalid), 64'd1);
      end
      axil_req.bready = 1'b1;
      @(negedge clk);
      axil_req.bready = 1'b0;
      check_value("bvalid", 64'(axil_rsp.bvalid), 64'd0);
   endtask

   task automatic check_all_counters();
      logic [31:0] data;
      logic [1:0]  resp;
      for (int ch = 0; ch < 4; ch++)
      begin
         for (int k = 0; k < 5; k++)
         begin
            read_reg(counter_addr(ch, k), data, resp);
            check_value($sformatf("counter[%0d][%0d]", ch, k), 64'(data),
                        64'(cnt_model[ch][k]));
            check_value("rresp", 64'(resp), 64'(cl_glue_pkg::RESP_OKAY));
         end
      end
   endtask

   task automatic check_status();
      logic [31:0] data;
      logic [1:0]  resp;
      read_reg(cl_glue_pkg::STATUS_ADDR, data, resp);
      check_value("scrub status", 64'(data), 64'(done_model));
      check_value("rresp", 64'(resp), 64'(cl_glue_pkg::RESP_OKAY));
   endtask

   initial
   begin
      logic [31:0] r;
      logic [31:0] data;
      logic [1:0]  resp;
      logic [3:0]  en_bits;
      logic        exp_flr;
      int          ch;
      mon_vec_t    mon;

      rng_state  = 32'd71;
      sync_rst_n = 1'b0;
      ctl0       = '0;
      flr_assert = 1'b0;
      ddr_mon    = '0;
      axil_req   = '0;
      en_model   = '0;
      done_model = '0;
      for (int c = 0; c < 4; c++)
      begin
         addr_model[c] = '0;
         for (int k = 0; k < 5; k++)
            cnt_model[c][k] = '0;
      end

      // ---------------------------------------------------------
      // Reset and release of the slices
      // ---------------------------------------------------------
      repeat (2) @(negedge clk);
      sync_rst_n = 1'b1;
      check_value("bvalid", 64'(axil_rsp.bvalid), 64'd0);
      check_value("rvalid", 64'(axil_rsp.rvalid), 64'd0);
      check_value("arready", 64'(axil_rsp.arready), 64'd0);
      check_value("flr_done", 64'(flr_done), 64'd0);
      repeat (RST_STAGES + 2) @(negedge clk);
      check_value("id0", 64'(id0), 64'(cl_glue_pkg::CL_ID0));
      check_value("id1", 64'(id1), 64'(cl_glue_pkg::CL_ID1));
      check_value("arready", 64'(axil_rsp.arready), 64'd1);

      // ---------------------------------------------------------
      // Random traffic on all channels, then counter readback
      // ---------------------------------------------------------
      repeat (400) apply_mon(random_mon());
      apply_mon('0);
      check_all_counters();

      // ---------------------------------------------------------
      // Scrub progress with random enables
      // ---------------------------------------------------------
      r       = next_rand();
      en_bits = r[19:16];
      if (en_bits == 4'd0)
         en_bits = 4'b1001;
      set_ctl({28'd0, en_bits});
      repeat (40) apply_mon(random_mon());
      apply_mon('0);
      check_status();

      // Restart all channels and give channel c exactly c+1 bursts
      set_ctl('0);
      en_bits = 4'hF;
      set_ctl({28'd0, en_bits});
      for (int n = 0; n < cl_glue_pkg::NUM_DDR; n++)
      begin
         mon = '0;
         for (int c = n; c < cl_glue_pkg::NUM_DDR; c++)
         begin
            mon[c].awvalid = 1'b1;
            mon[c].awready = 1'b1;
         end
         apply_mon(mon);
      end
      apply_mon('0);

      // Debug mux shows each channel's scrub address
      for (int s = 0; s < 8; s++)
      begin
         set_ctl({1'b1, 3'(s), 24'd0, en_bits});
         ch = sel_to_chan(3'(s));
         check_value("id0", 64'(id0), 64'(addr_model[ch][31:0]));
         check_value("id1", 64'(id1), 64'(addr_model[ch][63:32]));
      end

      set_ctl('0);
      check_status();
      check_value("id0", 64'(id0), 64'(cl_glue_pkg::CL_ID0));
      check_value("id1", 64'(id1), 64'(cl_glue_pkg::CL_ID1));

      // ---------------------------------------------------------
      // FLR acknowledge
      // ---------------------------------------------------------
      flr_assert = 1'b1;
      @(negedge clk);
      check_value("flr_done", 64'(flr_done), 64'd0);
      @(negedge clk);
      exp_flr = 1'b1;
      check_value("flr_done", 64'(flr_done), 64'(exp_flr));
      repeat (6)
      begin
         @(negedge clk);
         exp_flr = !exp_flr;
         check_value("flr_done", 64'(flr_done), 64'(exp_flr));
      end
      flr_assert = 1'b0;
      repeat (4) @(negedge clk);

      // ---------------------------------------------------------
      // Writes and unmapped reads get SLVERR
      // ---------------------------------------------------------
      r = next_rand();
      write_reg(counter_addr(1, 2), r, resp);
      check_value("bresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));
      write_reg(cl_glue_pkg::STATUS_ADDR, r, resp);
      check_value("bresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));
      write_reg((next_rand() | 32'h100) & ~32'h3, r, resp);
      check_value("bresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));

      for (int c = 0; c < 4; c++)
      begin
         read_reg(counter_addr(c, 5), data, resp);
         check_value("rdata", 64'(data), 64'd0);
         check_value("rresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));
      end
      read_reg(32'h84, data, resp);
      check_value("rdata", 64'(data), 64'd0);
      check_value("rresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));
      read_reg((next_rand() | 32'h100) & ~32'h3, data, resp);
      check_value("rdata", 64'(data), 64'd0);
      check_value("rresp", 64'(resp), 64'(cl_glue_pkg::RESP_SLVERR));

      // Scrub traffic also went through the counters
      check_all_counters();

      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
